/* project.f */
verilog/mem_bridge_pkg.sv
verilog/core_req_buffer.sv
verilog/axi_lite_port_fsm.sv
verilog/axi_lite_arbiter.sv
verilog/mem_bridge_top.sv
test/tb_axi_mem.sv
test/tb_mem_bridge.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the memory bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
   --top-module tb_mem_bridge -f project.f \
   --Mdir obj_dir -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation passed" sim.log; then
   exit 0
fi
echo "Testbench reported failure, see sim.log"
exit 1

/* test/tb_axi_mem.sv */
`timescale 1ns/1ps

module tb_axi_mem (
   input  logic                      clk_i,
   input  logic                      reset_i,
   input  logic                      ar_valid_i,
   input  mem_bridge_pkg::axi_addr_t ar_i,
   output logic                      ar_ready_o,
   input  logic                      aw_valid_i,
   input  mem_bridge_pkg::axi_addr_t aw_i,
   output logic                      aw_ready_o,
   input  logic                      w_valid_i,
   input  mem_bridge_pkg::axi_w_t    w_i,
   output logic                      w_ready_o,
   output logic                      r_valid_o,
   output mem_bridge_pkg::axi_r_t    r_o,
   input  logic                      r_ready_i,
   output logic                      b_valid_o,
   output mem_bridge_pkg::axi_resp_e b_resp_o,
   input  logic                      b_ready_i
);

   logic [31:0]               mem [0:255];  // Word index is address bits 9 to 2
   logic [1:0]                ar_wait, aw_wait, w_wait, r_wait, b_wait;
   logic                      r_pend, b_pend, aw_got, w_got;
   mem_bridge_pkg::axi_addr_t ar_q, aw_q;
   mem_bridge_pkg::axi_w_t    w_q;

   // Read side: AR ready delay, then R delay
   always @(posedge clk_i) begin
      if (reset_i) begin
         ar_ready_o <= 1'b0;
         ar_wait    <= 2'd0;
         r_pend     <= 1'b0;
         r_wait     <= 2'd0;
         r_valid_o  <= 1'b0;
         r_o        <= '0;
      end else begin
         if (ar_valid_i && ar_ready_o) begin
            ar_ready_o <= 1'b0;
            ar_q       <= ar_i;
            r_pend     <= 1'b1;
            ar_wait    <= 2'($urandom);
            r_wait     <= 2'($urandom);
         end else if (ar_valid_i && !r_pend && !r_valid_o) begin
            if (ar_wait == 2'd0) ar_ready_o <= 1'b1;
            else ar_wait <= ar_wait - 2'd1;
         end
         if (r_pend && !r_valid_o) begin
            if (r_wait == 2'd0) begin
               r_valid_o <= 1'b1;
               r_pend    <= 1'b0;
               if (ar_q.addr[31]) begin  // Error region
                  r_o.data <= '0;
                  r_o.resp <= mem_bridge_pkg::SLVERR;
               end else begin
                  r_o.data <= mem[ar_q.addr[9:2]];
                  r_o.resp <= mem_bridge_pkg::OKAY;
               end
            end else begin
               r_wait <= r_wait - 2'd1;
            end
         end else if (r_valid_o && r_ready_i) begin
            r_valid_o <= 1'b0;
         end
      end
   end

   // Write side: AW and W accepted on their own, B once both are in
   always @(posedge clk_i) begin
      if (reset_i) begin
         aw_ready_o <= 1'b0;
         w_ready_o  <= 1'b0;
         aw_wait    <= 2'd0;
         w_wait     <= 2'd0;
         aw_got     <= 1'b0;
         w_got      <= 1'b0;
         b_pend     <= 1'b0;
         b_wait     <= 2'd0;
         b_valid_o  <= 1'b0;
         b_resp_o   <= mem_bridge_pkg::OKAY;
         for (int i = 0; i < 256; i++) mem[i] <= '0;
      end else begin
         if (aw_valid_i && aw_ready_o) begin
            aw_ready_o <= 1'b0;
            aw_q       <= aw_i;
            aw_got     <= 1'b1;
            aw_wait    <= 2'($urandom);
         end else if (aw_valid_i && !aw_got) begin
            if (aw_wait == 2'd0) aw_ready_o <= 1'b1;
            else aw_wait <= aw_wait - 2'd1;
         end
         if (w_valid_i && w_ready_o) begin
            w_ready_o <= 1'b0;
            w_q       <= w_i;
            w_got     <= 1'b1;
            w_wait    <= 2'($urandom);
         end else if (w_valid_i && !w_got) begin
            if (w_wait == 2'd0) w_ready_o <= 1'b1;
            else w_wait <= w_wait - 2'd1;
         end
         if (aw_got && w_got) begin
            aw_got <= 1'b0;
            w_got  <= 1'b0;
            b_pend <= 1'b1;
            b_wait <= 2'($urandom);
            if (!aw_q.addr[31]) begin
               for (int b = 0; b < 4; b++) begin
                  if (w_q.strb[b]) mem[aw_q.addr[9:2]][8*b +: 8] <= w_q.data[8*b +: 8];
               end
            end
         end
         if (b_pend && !b_valid_o) begin
            if (b_wait == 2'd0) begin
               b_valid_o <= 1'b1;
               b_pend    <= 1'b0;
               b_resp_o  <= aw_q.addr[31] ? mem_bridge_pkg::SLVERR : mem_bridge_pkg::OKAY;
            end else begin
               b_wait <= b_wait - 2'd1;
            end
         end else if (b_valid_o && b_ready_i) begin
            b_valid_o <= 1'b0;
         end
      end
   end

endmodule

/* test/tb_mem_bridge.sv */
`timescale 1ns/1ps

module tb_mem_bridge;

   localparam int TIMEOUT = 200;

   logic                      clk, reset;
   logic                      instr_req, instr_gnt, instr_rvalid;
   logic [31:0]               instr_addr;
   mem_bridge_pkg::core_rsp_t instr_rsp;
   logic                      data_req, data_gnt, data_rvalid;
   mem_bridge_pkg::core_req_t data_info;
   mem_bridge_pkg::core_rsp_t data_rsp;
   logic                      ar_valid, ar_ready, aw_valid, aw_ready, w_valid, w_ready;
   logic                      r_valid, r_ready, b_valid, b_ready;
   mem_bridge_pkg::axi_addr_t ar, aw, last_ar, last_aw;
   mem_bridge_pkg::axi_w_t    w;
   mem_bridge_pkg::axi_r_t    r;
   mem_bridge_pkg::axi_resp_e b_resp;

   logic [31:0]               ref_mem [0:255];
   mem_bridge_pkg::core_rsp_t instr_exp[$];
   mem_bridge_pkg::core_rsp_t data_exp[$];
   string                     instr_name[$];
   string                     data_name[$];
   int                        errors;
   int                        timeouts;

   mem_bridge_top dut0 (
      .clk_i(clk), .reset_i(reset),
      .instr_req_i(instr_req), .instr_addr_i(instr_addr), .instr_gnt_o(instr_gnt),
      .instr_rvalid_o(instr_rvalid), .instr_rsp_o(instr_rsp),
      .data_req_i(data_req), .data_info_i(data_info), .data_gnt_o(data_gnt),
      .data_rvalid_o(data_rvalid), .data_rsp_o(data_rsp),
      .m_ar_valid_o(ar_valid), .m_ar_o(ar), .m_ar_ready_i(ar_ready),
      .m_aw_valid_o(aw_valid), .m_aw_o(aw), .m_aw_ready_i(aw_ready),
      .m_w_valid_o(w_valid), .m_w_o(w), .m_w_ready_i(w_ready),
      .m_r_valid_i(r_valid), .m_r_i(r), .m_r_ready_o(r_ready),
      .m_b_valid_i(b_valid), .m_b_resp_i(b_resp), .m_b_ready_o(b_ready)
   );

   tb_axi_mem u_mem (
      .clk_i(clk), .reset_i(reset),
      .ar_valid_i(ar_valid), .ar_i(ar), .ar_ready_o(ar_ready),
      .aw_valid_i(aw_valid), .aw_i(aw), .aw_ready_o(aw_ready),
      .w_valid_i(w_valid), .w_i(w), .w_ready_o(w_ready),
      .r_valid_o(r_valid), .r_o(r), .r_ready_i(r_ready),
      .b_valid_o(b_valid), .b_resp_o(b_resp), .b_ready_i(b_ready)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) begin
      if (ar_valid && ar_ready) last_ar <= ar;  // Most recent read address beat
      if (aw_valid && aw_ready) last_aw <= aw;  // Most recent write address beat
   end

   function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                               input logic [31:0] new_word,
                                               input logic [3:0] be);
      logic [31:0] res;
      res = old_word;
      for (int b = 0; b < 4; b++) begin
         if (be[b]) res[8*b +: 8] = new_word[8*b +: 8];
      end
      return res;
   endfunction

   task automatic check_rsp(input string name, input mem_bridge_pkg::core_rsp_t exp,
                            input mem_bridge_pkg::core_rsp_t act);
      if (act !== exp) begin
         errors++;
         $display("Fail %s: expected rdata %h err %b, actual rdata %h err %b",
                  name, exp.rdata, exp.err, act.rdata, act.err);
      end
   endtask

   task automatic check_prot(input string name, input logic [2:0] exp, input logic [2:0] act);
      if (act !== exp) begin
         errors++;
         $display("Fail %s: expected prot %b, actual prot %b", name, exp, act);
      end
   endtask

   task automatic check_addr(input string name, input logic [mem_bridge_pkg::ADDR_W-1:0] exp,
                             input logic [mem_bridge_pkg::ADDR_W-1:0] act);
      if (act !== exp) begin
         errors++;
         $display("Fail %s: expected address %h, actual address %h", name, exp, act);
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         errors++;
         $display("Fail %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   // Pops one expectation per rvalid, so each port is checked in request order
   task automatic collect_responses;
      mem_bridge_pkg::core_rsp_t exp;
      string                     name;
      forever begin
         @(negedge clk);
         if (instr_rvalid) begin
            if (instr_exp.size() == 0) begin
               errors++;
               $display("Response on the instruction port with no request outstanding");
            end else begin
               exp  = instr_exp.pop_front();
               name = instr_name.pop_front();
               check_rsp(name, exp, instr_rsp);
            end
         end
         if (data_rvalid) begin
            if (data_exp.size() == 0) begin
               errors++;
               $display("Response on the data port with no request outstanding");
            end else begin
               exp  = data_exp.pop_front();
               name = data_name.pop_front();
               check_rsp(name, exp, data_rsp);
            end
         end
      end
   endtask

   task automatic fetch(input string name, input logic [31:0] addr);
      mem_bridge_pkg::core_rsp_t exp;
      int                        n;
      @(negedge clk);
      instr_req  = 1'b1;
      instr_addr = addr;
      n = 0;
      #1;
      while (!instr_gnt && n < TIMEOUT) begin
         @(negedge clk);
         #1;
         n++;
      end
      if (instr_gnt) begin
         exp.err   = addr[31];
         exp.rdata = addr[31] ? 32'd0 : ref_mem[addr[9:2]];
         instr_exp.push_back(exp);
         instr_name.push_back(name);
      end else begin
         timeouts++;
         $display("%s: the instruction port was never granted", name);
      end
      @(negedge clk);
      instr_req = 1'b0;
   endtask

   task automatic data_access(input string name, input logic we, input logic [3:0] be,
                              input logic [31:0] addr, input logic [31:0] wdata);
      mem_bridge_pkg::core_rsp_t exp;
      int                        n;
      @(negedge clk);
      data_req        = 1'b1;
      data_info.we    = we;
      data_info.be    = be;
      data_info.addr  = addr;
      data_info.wdata = wdata;
      n = 0;
      #1;
      while (!data_gnt && n < TIMEOUT) begin
         @(negedge clk);
         #1;
         n++;
      end
      if (data_gnt) begin
         exp.err   = addr[31];
         exp.rdata = 32'd0;  // Writes and errors return zero data
         if (!addr[31] && we) ref_mem[addr[9:2]] = merge_bytes(ref_mem[addr[9:2]], wdata, be);
         else if (!addr[31]) exp.rdata = ref_mem[addr[9:2]];
         data_exp.push_back(exp);
         data_name.push_back(name);
      end else begin
         timeouts++;
         $display("%s: the data port was never granted", name);
      end
      @(negedge clk);
      data_req = 1'b0;
   endtask

   task automatic wait_idle(input string name);
      int n;
      n = 0;
      while ((instr_exp.size() != 0 || data_exp.size() != 0) && n < TIMEOUT) begin
         @(posedge clk);
         n++;
      end
      if (instr_exp.size() != 0 || data_exp.size() != 0) begin
         timeouts++;
         $display("%s: responses still missing after %0d cycles", name, TIMEOUT);
      end
   endtask

   task automatic reset_values;
      @(negedge clk);
      check_bit("reset instr_gnt", 1'b0, instr_gnt);
      check_bit("reset data_gnt", 1'b0, data_gnt);
      check_bit("reset instr_rvalid", 1'b0, instr_rvalid);
      check_bit("reset data_rvalid", 1'b0, data_rvalid);
      check_bit("reset ar_valid", 1'b0, ar_valid);
      check_bit("reset aw_valid", 1'b0, aw_valid);
   endtask

   task automatic byte_merge;
      data_access("byte_merge full write", 1'b1, 4'hf, 32'h10, 32'h1122_3344);
      data_access("byte_merge partial write", 1'b1, 4'b0101, 32'h10, 32'haabb_ccdd);
      data_access("byte_merge read", 1'b0, 4'hf, 32'h10, 32'd0);
      wait_idle("byte_merge");
   endtask

   task automatic fetch_after_write;
      data_access("fetch_after_write write", 1'b1, 4'hf, 32'h21, 32'hdead_beef);
      wait_idle("fetch_after_write write");
      check_prot("fetch_after_write write prot", mem_bridge_pkg::PROT_DATA, last_aw.prot);
      check_addr("fetch_after_write write addr", 32'h20, last_aw.addr);
      fetch("fetch_after_write fetch", 32'h22);
      wait_idle("fetch_after_write fetch");
      check_prot("fetch_after_write fetch prot", mem_bridge_pkg::PROT_INSTR, last_ar.prot);
      check_addr("fetch_after_write fetch addr", 32'h20, last_ar.addr);
      data_access("fetch_after_write load", 1'b0, 4'hf, 32'h23, 32'd0);
      wait_idle("fetch_after_write load");
      check_prot("fetch_after_write load prot", mem_bridge_pkg::PROT_DATA, last_ar.prot);
      check_addr("fetch_after_write load addr", 32'h20, last_ar.addr);
   endtask

   task automatic error_region;
      data_access("error_region setup", 1'b1, 4'hf, 32'h30, 32'h0bad_f00d);
      data_access("error_region write", 1'b1, 4'hf, 32'h8000_0030, 32'hffff_ffff);
      data_access("error_region read", 1'b0, 4'hf, 32'h8000_0030, 32'd0);
      data_access("error_region alias read", 1'b0, 4'hf, 32'h30, 32'd0);
      wait_idle("error_region");
   endtask

   // Fetches stay in words 0 to 15, data traffic in words 64 to 127
   task automatic random_rounds;
      logic [31:0] rnd, iaddr, daddr, wdata;
      string       name;
      for (int i = 0; i < 16; i++) begin
         data_access($sformatf("random preload %0d", i), 1'b1, 4'hf, 32'(i * 4), $urandom);
      end
      wait_idle("random preload");
      for (int i = 0; i < 20; i++) begin
         rnd   = $urandom;
         wdata = $urandom;
         iaddr = {26'd0, rnd[3:0], rnd[5:4]};
         daddr = {22'd0, 2'b01, rnd[11:6], rnd[13:12]};
         name  = $sformatf("random round %0d", i);
         fork
            fetch(name, iaddr);
            data_access(name, rnd[14], rnd[18:15], daddr, wdata);
         join
      end
      wait_idle("random rounds");
   endtask

   initial begin
      void'($urandom(32'h0727_87b5));
      errors     = 0;
      timeouts   = 0;
      reset      = 1'b1;
      instr_req  = 1'b0;
      instr_addr = '0;
      data_req   = 1'b0;
      data_info  = '0;
      for (int i = 0; i < 256; i++) ref_mem[i] = '0;
      repeat (5) @(negedge clk);
      reset = 1'b0;
      fork
         collect_responses();
      join_none
      reset_values();
      byte_merge();
      fetch_after_write();
      error_region();
      random_rounds();
      repeat (5) @(negedge clk);
      $display("Summary: %0d check errors, %0d timeouts", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

/* verilog/axi_lite_arbiter.sv */
`timescale 1ns/1ps

module axi_lite_arbiter (
   input  logic                                                      clk_i,
   input  logic                                                      reset_i,
   input  logic [mem_bridge_pkg::NUM_PORTS-1:0]                      rd_valid_i,
   input  logic [mem_bridge_pkg::NUM_PORTS-1:0][mem_bridge_pkg::ADDR_W-1:0] rd_addr_i,
   output logic [mem_bridge_pkg::NUM_PORTS-1:0]                      rd_ready_o,
   input  logic [mem_bridge_pkg::NUM_PORTS-1:0]                      wr_valid_i,
   input  logic [mem_bridge_pkg::NUM_PORTS-1:0][mem_bridge_pkg::ADDR_W-1:0] wr_addr_i,
   input  mem_bridge_pkg::axi_w_t [mem_bridge_pkg::NUM_PORTS-1:0]    wr_beat_i,
   output logic [mem_bridge_pkg::NUM_PORTS-1:0]                      wr_ready_o,
   output logic [mem_bridge_pkg::NUM_PORTS-1:0]                      rsp_valid_o,
   output mem_bridge_pkg::axi_r_t [mem_bridge_pkg::NUM_PORTS-1:0]    rsp_o,
   output logic                                                      m_ar_valid_o,
   output mem_bridge_pkg::axi_addr_t                                 m_ar_o,
   input  logic                                                      m_ar_ready_i,
   output logic                                                      m_aw_valid_o,
   output mem_bridge_pkg::axi_addr_t                                 m_aw_o,
   input  logic                                                      m_aw_ready_i,
   output logic                                                      m_w_valid_o,
   output mem_bridge_pkg::axi_w_t                                    m_w_o,
   input  logic                                                      m_w_ready_i,
   input  logic                                                      m_r_valid_i,
   input  mem_bridge_pkg::axi_r_t                                    m_r_i,
   output logic                                                      m_r_ready_o,
   input  logic                                                      m_b_valid_i,
   input  mem_bridge_pkg::axi_resp_e                                 m_b_resp_i,
   output logic                                                      m_b_ready_o
);

   mem_bridge_pkg::port_state_e          bus_q;     // Phase of the single outstanding beat
   mem_bridge_pkg::port_id_t             owner_q;
   mem_bridge_pkg::port_id_t             rr_q;      // Port favored at the next pick
   mem_bridge_pkg::port_id_t             pick;
   logic                                 is_wr_q;
   logic                                 aw_pend_q;
   logic                                 w_pend_q;
   logic [mem_bridge_pkg::NUM_PORTS-1:0] req_any;
   logic [2:0]                           prot;
   logic                                 ar_hs, aw_hs, w_hs, r_hs, b_hs;
   logic                                 wr_last;
   mem_bridge_pkg::axi_r_t               rsp_beat;

   assign req_any = rd_valid_i | wr_valid_i;
   assign pick    = req_any[rr_q] ? rr_q : ~rr_q;
   assign prot    = (owner_q == mem_bridge_pkg::port_id_t'(mem_bridge_pkg::PORT_INSTR)) ?
                    mem_bridge_pkg::PROT_INSTR : mem_bridge_pkg::PROT_DATA;

   assign m_ar_valid_o = (bus_q == mem_bridge_pkg::PORT_ADDR) & ~is_wr_q;
   assign m_aw_valid_o = (bus_q == mem_bridge_pkg::PORT_ADDR) & aw_pend_q;
   assign m_w_valid_o  = (bus_q == mem_bridge_pkg::PORT_ADDR) & w_pend_q;
   assign m_r_ready_o  = (bus_q == mem_bridge_pkg::PORT_RESP) & ~is_wr_q;
   assign m_b_ready_o  = (bus_q == mem_bridge_pkg::PORT_RESP) & is_wr_q;

   assign m_ar_o.addr = rd_addr_i[owner_q];
   assign m_ar_o.prot = prot;
   assign m_aw_o.addr = wr_addr_i[owner_q];
   assign m_aw_o.prot = prot;
   assign m_w_o       = wr_beat_i[owner_q];

   assign ar_hs = m_ar_valid_o & m_ar_ready_i;
   assign aw_hs = m_aw_valid_o & m_aw_ready_i;
   assign w_hs  = m_w_valid_o & m_w_ready_i;
   assign r_hs  = m_r_valid_i & m_r_ready_o;
   assign b_hs  = m_b_valid_i & m_b_ready_o;

   // Write address phase ends when neither AW nor W is left pending
   assign wr_last = (bus_q == mem_bridge_pkg::PORT_ADDR) & is_wr_q &
                    (~aw_pend_q | aw_hs) & (~w_pend_q | w_hs);

   // A write reply carries zero data
   assign rsp_beat.data = is_wr_q ? '0 : m_r_i.data;
   assign rsp_beat.resp = is_wr_q ? m_b_resp_i : m_r_i.resp;

   always_comb begin
      for (int p = 0; p < mem_bridge_pkg::NUM_PORTS; p++) begin
         rd_ready_o[p]  = (owner_q == mem_bridge_pkg::port_id_t'(p)) & ar_hs;
         wr_ready_o[p]  = (owner_q == mem_bridge_pkg::port_id_t'(p)) & wr_last;
         rsp_valid_o[p] = (owner_q == mem_bridge_pkg::port_id_t'(p)) & (r_hs | b_hs);
         rsp_o[p]       = rsp_beat;
      end
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         bus_q     <= mem_bridge_pkg::PORT_IDLE;
         owner_q   <= mem_bridge_pkg::port_id_t'(mem_bridge_pkg::PORT_INSTR);
         rr_q      <= mem_bridge_pkg::port_id_t'(mem_bridge_pkg::PORT_INSTR);
         is_wr_q   <= 1'b0;
         aw_pend_q <= 1'b0;
         w_pend_q  <= 1'b0;
      end else begin
         case (bus_q)
            mem_bridge_pkg::PORT_IDLE: begin
               if (|req_any) begin
                  owner_q   <= pick;
                  rr_q      <= ~pick;  // Other port goes first next time
                  is_wr_q   <= wr_valid_i[pick];
                  aw_pend_q <= wr_valid_i[pick];
                  w_pend_q  <= wr_valid_i[pick];
                  bus_q     <= mem_bridge_pkg::PORT_ADDR;
               end
            end
            mem_bridge_pkg::PORT_ADDR: begin
               if (aw_hs) aw_pend_q <= 1'b0;
               if (w_hs) w_pend_q <= 1'b0;
               if (ar_hs || wr_last) bus_q <= mem_bridge_pkg::PORT_RESP;
            end
            mem_bridge_pkg::PORT_RESP: begin
               if (r_hs || b_hs) bus_q <= mem_bridge_pkg::PORT_IDLE;
            end
            default: bus_q <= mem_bridge_pkg::PORT_IDLE;
         endcase
      end
   end

endmodule

/* verilog/axi_lite_port_fsm.sv */
`timescale 1ns/1ps

module axi_lite_port_fsm (
   input  logic                              clk_i,
   input  logic                              reset_i,
   input  logic                              req_valid_i,
   input  mem_bridge_pkg::core_req_t         req_i,
   output logic                              req_ready_o,
   output logic                              rd_valid_o,
   output logic [mem_bridge_pkg::ADDR_W-1:0] rd_addr_o,
   input  logic                              rd_ready_i,
   output logic                              wr_valid_o,
   output logic [mem_bridge_pkg::ADDR_W-1:0] wr_addr_o,
   output mem_bridge_pkg::axi_w_t            wr_beat_o,
   input  logic                              wr_ready_i,
   input  logic                              rsp_valid_i,
   input  mem_bridge_pkg::axi_r_t            rsp_i,
   output logic                              done_o,
   output mem_bridge_pkg::core_rsp_t         done_rsp_o
);

   mem_bridge_pkg::port_state_e      state_q;
   mem_bridge_pkg::port_state_e      state_d;
   mem_bridge_pkg::core_req_t        req_q;
   logic [mem_bridge_pkg::ADDR_W-1:0] addr_aligned;
   logic                             rsp_err;
   logic                             done_q;
   mem_bridge_pkg::core_rsp_t        done_rsp_q;

   assign req_ready_o  = (state_q == mem_bridge_pkg::PORT_IDLE);
   assign addr_aligned = {req_q.addr[mem_bridge_pkg::ADDR_W-1:2], 2'b00};

   always_comb begin
      state_d = state_q;
      case (state_q)
         mem_bridge_pkg::PORT_IDLE: begin
            if (req_valid_i) state_d = mem_bridge_pkg::PORT_ADDR;
         end
         mem_bridge_pkg::PORT_ADDR: begin
            // Leave once the arbiter has taken the address (and data)
            if ((rd_valid_o && rd_ready_i) || (wr_valid_o && wr_ready_i)) begin
               state_d = mem_bridge_pkg::PORT_RESP;
            end
         end
         mem_bridge_pkg::PORT_RESP: begin
            if (rsp_valid_i) state_d = mem_bridge_pkg::PORT_IDLE;
         end
         default: state_d = mem_bridge_pkg::PORT_IDLE;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_q <= mem_bridge_pkg::PORT_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   always_ff @(posedge clk_i) begin
      if (req_valid_i && req_ready_o) req_q <= req_i;
   end

   assign rd_valid_o     = (state_q == mem_bridge_pkg::PORT_ADDR) & ~req_q.we;
   assign wr_valid_o     = (state_q == mem_bridge_pkg::PORT_ADDR) & req_q.we;
   assign rd_addr_o      = addr_aligned;
   assign wr_addr_o      = addr_aligned;
   assign wr_beat_o.data = req_q.wdata;
   assign wr_beat_o.strb = req_q.be;

   // Slave and decode errors both count as bus faults
   assign rsp_err = (rsp_i.resp == mem_bridge_pkg::SLVERR) ||
                    (rsp_i.resp == mem_bridge_pkg::DECERR);

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         done_q <= 1'b0;
      end else begin
         done_q <= (state_q == mem_bridge_pkg::PORT_RESP) & rsp_valid_i;  // One-cycle pulse
      end
   end

   always_ff @(posedge clk_i) begin
      if (rsp_valid_i) begin
         done_rsp_q.rdata <= rsp_i.data;
         done_rsp_q.err   <= rsp_err;
      end
   end

   assign done_o     = done_q;
   assign done_rsp_o = done_rsp_q;

endmodule

/* verilog/core_req_buffer.sv */
`timescale 1ns/1ps

module core_req_buffer (
   input  logic                                                  clk_i,
   input  logic                                                  reset_i,
   input  logic                                                  instr_req_i,
   input  logic [mem_bridge_pkg::ADDR_W-1:0]                     instr_addr_i,
   output logic                                                  instr_gnt_o,
   input  logic                                                  data_req_i,
   input  mem_bridge_pkg::core_req_t                             data_info_i,
   output logic                                                  data_gnt_o,
   output logic [mem_bridge_pkg::NUM_PORTS-1:0]                  req_valid_o,
   output mem_bridge_pkg::core_req_t [mem_bridge_pkg::NUM_PORTS-1:0] req_o,
   input  logic [mem_bridge_pkg::NUM_PORTS-1:0]                  req_ready_i
);

   logic [mem_bridge_pkg::NUM_PORTS-1:0]                      in_valid;
   mem_bridge_pkg::core_req_t [mem_bridge_pkg::NUM_PORTS-1:0] in_req;
   logic [mem_bridge_pkg::NUM_PORTS-1:0]                      gnt;
   logic [mem_bridge_pkg::NUM_PORTS-1:0]                      full_q;
   mem_bridge_pkg::core_req_t [mem_bridge_pkg::NUM_PORTS-1:0] slot_q;

   // Fetches become plain full-word reads
   always_comb begin
      in_valid[mem_bridge_pkg::PORT_INSTR]     = instr_req_i;
      in_req[mem_bridge_pkg::PORT_INSTR].we    = 1'b0;
      in_req[mem_bridge_pkg::PORT_INSTR].be    = '1;
      in_req[mem_bridge_pkg::PORT_INSTR].addr  = instr_addr_i;
      in_req[mem_bridge_pkg::PORT_INSTR].wdata = '0;
      in_valid[mem_bridge_pkg::PORT_DATA]      = data_req_i;
      in_req[mem_bridge_pkg::PORT_DATA]        = data_info_i;
   end

   // Slot free, or its entry leaves this cycle
   assign gnt = in_valid & (~full_q | req_ready_i);

   always_ff @(posedge clk_i) begin
      for (int p = 0; p < mem_bridge_pkg::NUM_PORTS; p++) begin
         if (reset_i) begin
            full_q[p] <= 1'b0;
         end else if (gnt[p]) begin
            full_q[p] <= 1'b1;
         end else if (req_ready_i[p]) begin
            full_q[p] <= 1'b0;  // Drained by the port FSM
         end
      end
   end

   always_ff @(posedge clk_i) begin
      for (int p = 0; p < mem_bridge_pkg::NUM_PORTS; p++) begin
         if (gnt[p]) slot_q[p] <= in_req[p];
      end
   end

   assign instr_gnt_o = gnt[mem_bridge_pkg::PORT_INSTR];
   assign data_gnt_o  = gnt[mem_bridge_pkg::PORT_DATA];
   assign req_valid_o = full_q;
   assign req_o       = slot_q;

endmodule

/* verilog/mem_bridge_pkg.sv */
package mem_bridge_pkg;

   // Bus widths
   localparam int ADDR_W    = 32;
   localparam int DATA_W    = 32;
   localparam int STRB_W    = DATA_W / 8;

   // Core ports feeding the shared master
   localparam int NUM_PORTS  = 2;
   localparam int PORT_INSTR = 0;
   localparam int PORT_DATA  = 1;

   // AXI protection attribute, bit 2 marks an instruction access
   localparam logic [2:0] PROT_INSTR = 3'b100;
   localparam logic [2:0] PROT_DATA  = 3'b000;

   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      EXOKAY = 2'b01,
      SLVERR = 2'b10,
      DECERR = 2'b11
   } axi_resp_e;

   // Shared by the port FSM and the bus phase tracking in the arbiter
   typedef enum logic [1:0] {
      PORT_IDLE = 2'd0,
      PORT_ADDR = 2'd1,
      PORT_RESP = 2'd2
   } port_state_e;

   typedef struct packed {
      logic              we;
      logic [STRB_W-1:0] be;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
   } core_req_t;

   typedef struct packed {
      logic [DATA_W-1:0] rdata;
      logic              err;
   } core_rsp_t;

   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [2:0]        prot;
   } axi_addr_t;

   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic [STRB_W-1:0] strb;
   } axi_w_t;

   typedef struct packed {
      logic [DATA_W-1:0] data;
      axi_resp_e         resp;
   } axi_r_t;

   typedef logic [0:0] port_id_t;

endpackage

/* verilog/mem_bridge_top.sv */
`timescale 1ns/1ps

module mem_bridge_top (
   input  logic                              clk_i,
   input  logic                              reset_i,
   // Instruction fetch port
   input  logic                              instr_req_i,
   input  logic [mem_bridge_pkg::ADDR_W-1:0] instr_addr_i,
   output logic                              instr_gnt_o,
   output logic                              instr_rvalid_o,
   output mem_bridge_pkg::core_rsp_t         instr_rsp_o,
   // Load/store port
   input  logic                              data_req_i,
   input  mem_bridge_pkg::core_req_t         data_info_i,
   output logic                              data_gnt_o,
   output logic                              data_rvalid_o,
   output mem_bridge_pkg::core_rsp_t         data_rsp_o,
   // AXI4-Lite master
   output logic                              m_ar_valid_o,
   output mem_bridge_pkg::axi_addr_t         m_ar_o,
   input  logic                              m_ar_ready_i,
   output logic                              m_aw_valid_o,
   output mem_bridge_pkg::axi_addr_t         m_aw_o,
   input  logic                              m_aw_ready_i,
   output logic                              m_w_valid_o,
   output mem_bridge_pkg::axi_w_t            m_w_o,
   input  logic                              m_w_ready_i,
   input  logic                              m_r_valid_i,
   input  mem_bridge_pkg::axi_r_t            m_r_i,
   output logic                              m_r_ready_o,
   input  logic                              m_b_valid_i,
   input  mem_bridge_pkg::axi_resp_e         m_b_resp_i,
   output logic                              m_b_ready_o
);

   localparam int N = mem_bridge_pkg::NUM_PORTS;

   logic [N-1:0]                             req_valid, req_ready;
   mem_bridge_pkg::core_req_t [N-1:0]        req;
   logic [N-1:0]                             rd_valid, rd_ready;
   logic [N-1:0][mem_bridge_pkg::ADDR_W-1:0] rd_addr, wr_addr;
   logic [N-1:0]                             wr_valid, wr_ready;
   mem_bridge_pkg::axi_w_t [N-1:0]           wr_beat;
   logic [N-1:0]                             rsp_valid, done;
   mem_bridge_pkg::axi_r_t [N-1:0]           rsp;
   mem_bridge_pkg::core_rsp_t [N-1:0]        done_rsp;

   core_req_buffer u_buffer (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .instr_req_i (instr_req_i),
      .instr_addr_i(instr_addr_i),
      .instr_gnt_o (instr_gnt_o),
      .data_req_i  (data_req_i),
      .data_info_i (data_info_i),
      .data_gnt_o  (data_gnt_o),
      .req_valid_o (req_valid),
      .req_o       (req),
      .req_ready_i (req_ready)
   );

   // One FSM per core port
   for (genvar p = 0; p < N; p++) begin : g_port
      axi_lite_port_fsm u_fsm (
         .clk_i      (clk_i),
         .reset_i    (reset_i),
         .req_valid_i(req_valid[p]),
         .req_i      (req[p]),
         .req_ready_o(req_ready[p]),
         .rd_valid_o (rd_valid[p]),
         .rd_addr_o  (rd_addr[p]),
         .rd_ready_i (rd_ready[p]),
         .wr_valid_o (wr_valid[p]),
         .wr_addr_o  (wr_addr[p]),
         .wr_beat_o  (wr_beat[p]),
         .wr_ready_i (wr_ready[p]),
         .rsp_valid_i(rsp_valid[p]),
         .rsp_i      (rsp[p]),
         .done_o     (done[p]),
         .done_rsp_o (done_rsp[p])
      );
   end

   axi_lite_arbiter u_arbiter (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .rd_valid_i  (rd_valid),
      .rd_addr_i   (rd_addr),
      .rd_ready_o  (rd_ready),
      .wr_valid_i  (wr_valid),
      .wr_addr_i   (wr_addr),
      .wr_beat_i   (wr_beat),
      .wr_ready_o  (wr_ready),
      .rsp_valid_o (rsp_valid),
      .rsp_o       (rsp),
      .m_ar_valid_o(m_ar_valid_o),
      .m_ar_o      (m_ar_o),
      .m_ar_ready_i(m_ar_ready_i),
      .m_aw_valid_o(m_aw_valid_o),
      .m_aw_o      (m_aw_o),
      .m_aw_ready_i(m_aw_ready_i),
      .m_w_valid_o (m_w_valid_o),
      .m_w_o       (m_w_o),
      .m_w_ready_i (m_w_ready_i),
      .m_r_valid_i (m_r_valid_i),
      .m_r_i       (m_r_i),
      .m_r_ready_o (m_r_ready_o),
      .m_b_valid_i (m_b_valid_i),
      .m_b_resp_i  (m_b_resp_i),
      .m_b_ready_o (m_b_ready_o)
   );

   assign instr_rvalid_o = done[mem_bridge_pkg::PORT_INSTR];
   assign instr_rsp_o    = done_rsp[mem_bridge_pkg::PORT_INSTR];
   assign data_rvalid_o  = done[mem_bridge_pkg::PORT_DATA];
   assign data_rsp_o     = done_rsp[mem_bridge_pkg::PORT_DATA];

endmodule
